// ==== apu.f ====
rtl/apu_pkg.sv
rtl/apu_regs.sv
rtl/frame_sequencer.sv
rtl/volume_envelope.sv
rtl/square_voice.sv
rtl/noise_voice.sv
rtl/stereo_mixer.sv
rtl/apu_top.sv
verif/tb_clock.sv
verif/apu_tb.sv

// ==== rtl/apu_pkg.sv ====
package apu_pkg;

	typedef logic [3:0] level_t; // Output level of one voice.
	typedef logic [5:0] mix_t;   // Mixed level of one side.

	parameter level_t LEVEL_IDLE = 4'd8;
	parameter mix_t   MIX_IDLE   = 6'd32; // Four idle slots, wave slot included.
	parameter mix_t   MIX_MAX    = 6'd60;

	// Voice 1 registers.
	parameter logic [5:0] NR11 = 6'h11;
	parameter logic [5:0] NR12 = 6'h12;
	parameter logic [5:0] NR13 = 6'h13;
	parameter logic [5:0] NR14 = 6'h14;

	// Voice 2 registers.
	parameter logic [5:0] NR21 = 6'h16;
	parameter logic [5:0] NR22 = 6'h17;
	parameter logic [5:0] NR23 = 6'h18;
	parameter logic [5:0] NR24 = 6'h19;

	// Noise voice registers.
	parameter logic [5:0] NR41 = 6'h20;
	parameter logic [5:0] NR42 = 6'h21;
	parameter logic [5:0] NR43 = 6'h22;
	parameter logic [5:0] NR44 = 6'h23;

	// Routing and master on/off.
	parameter logic [5:0] NR51 = 6'h25;
	parameter logic [5:0] NR52 = 6'h26;

	// Duty step at which the square pulse goes high, per duty setting.
	parameter logic [2:0] DUTY_THRESHOLD [4] = '{3'd1, 3'd2, 3'd4, 3'd6};

endpackage

// ==== rtl/apu_regs.sv ====
`timescale 1ns/1ns

module apu_regs import apu_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic [5:0]  addr,
	input  logic [7:0]  din,
	input  logic        write,
	output logic        master_ena,
	output logic [2:0]  route_left,
	output logic [2:0]  route_right,
	output logic [1:0]  sq1_duty,
	output logic [5:0]  sq1_length,
	output logic [3:0]  sq1_vol_init,
	output logic        sq1_vol_inc,
	output logic [2:0]  sq1_vol_period,
	output logic [10:0] sq1_freq,
	output logic        sq1_length_ena,
	output logic        sq1_trigger,
	output logic [1:0]  sq2_duty,
	output logic [5:0]  sq2_length,
	output logic [3:0]  sq2_vol_init,
	output logic        sq2_vol_inc,
	output logic [2:0]  sq2_vol_period,
	output logic [10:0] sq2_freq,
	output logic        sq2_length_ena,
	output logic        sq2_trigger,
	output logic [5:0]  ns_length,
	output logic [3:0]  ns_vol_init,
	output logic        ns_vol_inc,
	output logic [2:0]  ns_vol_period,
	output logic [3:0]  ns_shift,
	output logic        ns_width,
	output logic [2:0]  ns_div,
	output logic        ns_length_ena,
	output logic        ns_trigger
);

	logic write_prev;
	logic commit;

	assign commit = write_prev && !write; // Falling edge of write.

	always_ff @(posedge clk) begin
		write_prev  <= write;
		sq1_trigger <= 1'b0;
		sq2_trigger <= 1'b0;
		ns_trigger  <= 1'b0;

		if (commit) begin
			if (master_ena) begin
				case (addr)
					NR11: {sq1_duty, sq1_length} <= din;
					NR12: {sq1_vol_init, sq1_vol_inc, sq1_vol_period} <= din;
					NR13: sq1_freq[7:0] <= din;
					NR14: begin
						sq1_trigger    <= din[7];
						sq1_length_ena <= din[6];
						sq1_freq[10:8] <= din[2:0];
					end
					NR21: {sq2_duty, sq2_length} <= din;
					NR22: {sq2_vol_init, sq2_vol_inc, sq2_vol_period} <= din;
					NR23: sq2_freq[7:0] <= din;
					NR24: begin
						sq2_trigger    <= din[7];
						sq2_length_ena <= din[6];
						sq2_freq[10:8] <= din[2:0];
					end
					NR41: ns_length <= din[5:0];
					NR42: {ns_vol_init, ns_vol_inc, ns_vol_period} <= din;
					NR43: {ns_shift, ns_width, ns_div} <= din;
					NR44: begin
						ns_trigger    <= din[7];
						ns_length_ena <= din[6];
					end
					NR51: begin
						// Upper nibble is left, lower is right. Wave bits 6 and 2 are ignored.
						route_left  <= {din[7], din[5], din[4]};
						route_right <= {din[3], din[1], din[0]};
					end
					NR52: master_ena <= din[7];
					default: ;
				endcase
			end else if (addr == NR52 && din[7]) begin
				master_ena <= 1'b1; // Only way back on.
			end
		end

		if (!master_ena) begin // Lengths survive power off.
			sq1_duty       <= '0;
			sq1_vol_init   <= '0;
			sq1_vol_inc    <= 1'b0;
			sq1_vol_period <= '0;
			sq1_freq       <= '0;
			sq1_length_ena <= 1'b0;
			sq2_duty       <= '0;
			sq2_vol_init   <= '0;
			sq2_vol_inc    <= 1'b0;
			sq2_vol_period <= '0;
			sq2_freq       <= '0;
			sq2_length_ena <= 1'b0;
			ns_vol_init    <= '0;
			ns_vol_inc     <= 1'b0;
			ns_vol_period  <= '0;
			ns_shift       <= '0;
			ns_width       <= 1'b0;
			ns_div         <= '0;
			ns_length_ena  <= 1'b0;
			route_left     <= '0;
			route_right    <= '0;
		end

		if (reset) begin
			write_prev  <= 1'b0;
			master_ena  <= 1'b0;
			sq1_trigger <= 1'b0;
			sq2_trigger <= 1'b0;
			ns_trigger  <= 1'b0;
			sq1_length  <= '0;
			sq2_length  <= '0;
			ns_length   <= '0;
		end
	end

	// A second trigger pulse would reload a voice twice for one write.
	trigger_single: assert property (@(posedge clk) disable iff (reset)
		({sq1_trigger, sq2_trigger, ns_trigger} &
		 $past({sq1_trigger, sq2_trigger, ns_trigger})) == 3'b000);

endmodule

// ==== rtl/apu_top.sv ====
`timescale 1ns/1ns

module apu_top import apu_pkg::*; #(
	parameter int DIV_BITS = 13
) (
	input  logic       clk,
	input  logic       reset,
	input  logic [5:0] addr,
	input  logic [7:0] din,
	input  logic       write,
	output mix_t       left,
	output mix_t       right
);

	logic        master_ena;
	logic [2:0]  route_left;
	logic [2:0]  route_right;
	logic        freq_tick;
	logic        length_tick;
	logic        env_tick;

	logic [1:0]  sq1_duty;
	logic [5:0]  sq1_length;
	logic [3:0]  sq1_vol_init;
	logic        sq1_vol_inc;
	logic [2:0]  sq1_vol_period;
	logic [10:0] sq1_freq;
	logic        sq1_length_ena;
	logic        sq1_trigger;
	level_t      sq1_level;

	logic [1:0]  sq2_duty;
	logic [5:0]  sq2_length;
	logic [3:0]  sq2_vol_init;
	logic        sq2_vol_inc;
	logic [2:0]  sq2_vol_period;
	logic [10:0] sq2_freq;
	logic        sq2_length_ena;
	logic        sq2_trigger;
	level_t      sq2_level;

	logic [5:0]  ns_length;
	logic [3:0]  ns_vol_init;
	logic        ns_vol_inc;
	logic [2:0]  ns_vol_period;
	logic [3:0]  ns_shift;
	logic        ns_width;
	logic [2:0]  ns_div;
	logic        ns_length_ena;
	logic        ns_trigger;
	level_t      ns_level;

	apu_regs u_regs (
		.clk            (clk),
		.reset          (reset),
		.addr           (addr),
		.din            (din),
		.write          (write),
		.master_ena     (master_ena),
		.route_left     (route_left),
		.route_right    (route_right),
		.sq1_duty       (sq1_duty),
		.sq1_length     (sq1_length),
		.sq1_vol_init   (sq1_vol_init),
		.sq1_vol_inc    (sq1_vol_inc),
		.sq1_vol_period (sq1_vol_period),
		.sq1_freq       (sq1_freq),
		.sq1_length_ena (sq1_length_ena),
		.sq1_trigger    (sq1_trigger),
		.sq2_duty       (sq2_duty),
		.sq2_length     (sq2_length),
		.sq2_vol_init   (sq2_vol_init),
		.sq2_vol_inc    (sq2_vol_inc),
		.sq2_vol_period (sq2_vol_period),
		.sq2_freq       (sq2_freq),
		.sq2_length_ena (sq2_length_ena),
		.sq2_trigger    (sq2_trigger),
		.ns_length      (ns_length),
		.ns_vol_init    (ns_vol_init),
		.ns_vol_inc     (ns_vol_inc),
		.ns_vol_period  (ns_vol_period),
		.ns_shift       (ns_shift),
		.ns_width       (ns_width),
		.ns_div         (ns_div),
		.ns_length_ena  (ns_length_ena),
		.ns_trigger     (ns_trigger)
	);

	frame_sequencer #(
		.DIV_BITS (DIV_BITS)
	) u_seq (
		.clk         (clk),
		.reset       (reset),
		.master_ena  (master_ena),
		.freq_tick   (freq_tick),
		.length_tick (length_tick),
		.env_tick    (env_tick)
	);

	square_voice u_sq1 (
		.clk         (clk),
		.reset       (reset),
		.master_ena  (master_ena),
		.trigger     (sq1_trigger),
		.freq_tick   (freq_tick),
		.length_tick (length_tick),
		.env_tick    (env_tick),
		.duty        (sq1_duty),
		.length      (sq1_length),
		.length_ena  (sq1_length_ena),
		.freq        (sq1_freq),
		.vol_init    (sq1_vol_init),
		.vol_inc     (sq1_vol_inc),
		.vol_period  (sq1_vol_period),
		.level       (sq1_level)
	);

	square_voice u_sq2 (
		.clk         (clk),
		.reset       (reset),
		.master_ena  (master_ena),
		.trigger     (sq2_trigger),
		.freq_tick   (freq_tick),
		.length_tick (length_tick),
		.env_tick    (env_tick),
		.duty        (sq2_duty),
		.length      (sq2_length),
		.length_ena  (sq2_length_ena),
		.freq        (sq2_freq),
		.vol_init    (sq2_vol_init),
		.vol_inc     (sq2_vol_inc),
		.vol_period  (sq2_vol_period),
		.level       (sq2_level)
	);

	noise_voice u_noise (
		.clk         (clk),
		.reset       (reset),
		.master_ena  (master_ena),
		.trigger     (ns_trigger),
		.freq_tick   (freq_tick),
		.length_tick (length_tick),
		.env_tick    (env_tick),
		.length      (ns_length),
		.length_ena  (ns_length_ena),
		.shift       (ns_shift),
		.width       (ns_width),
		.div         (ns_div),
		.vol_init    (ns_vol_init),
		.vol_inc     (ns_vol_inc),
		.vol_period  (ns_vol_period),
		.level       (ns_level)
	);

	stereo_mixer u_mix (
		.clk         (clk),
		.reset       (reset),
		.master_ena  (master_ena),
		.route_left  (route_left),
		.route_right (route_right),
		.sq1_level   (sq1_level),
		.sq2_level   (sq2_level),
		.ns_level    (ns_level),
		.left        (left),
		.right       (right)
	);

endmodule

// ==== rtl/frame_sequencer.sv ====
`timescale 1ns/1ns

module frame_sequencer #(
	parameter int DIV_BITS = 13
) (
	input  logic clk,
	input  logic reset,
	input  logic master_ena,
	output logic freq_tick,
	output logic length_tick,
	output logic env_tick
);

	logic [DIV_BITS-1:0] div;
	logic [2:0]          step;
	logic                wrap;

	assign wrap = &div;

	always_ff @(posedge clk) begin
		if (reset || !master_ena) begin
			div  <= '0;
			step <= '0;
		end else begin
			div <= div + 1'b1;
			if (wrap)
				step <= step + 3'd1; // Eight steps per frame.
		end
	end

	assign freq_tick   = &div[1:0];             // Quarter clock rate.
	assign length_tick = wrap && !step[0];      // Steps 0, 2, 4, 6.
	assign env_tick    = wrap && (step == 3'd7);

endmodule

// ==== rtl/noise_voice.sv ====
`timescale 1ns/1ns

module noise_voice import apu_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       master_ena,
	input  logic       trigger,
	input  logic       freq_tick,
	input  logic       length_tick,
	input  logic       env_tick,
	input  logic [5:0] length,
	input  logic       length_ena,
	input  logic [3:0] shift,
	input  logic       width,
	input  logic [2:0] div,
	input  logic [3:0] vol_init,
	input  logic       vol_inc,
	input  logic [2:0] vol_period,
	output level_t     level
);

	logic        ena;
	logic [17:0] freq_cnt;
	logic [17:0] reload;
	logic [14:0] lfsr;
	logic [14:0] lfsr_next;
	logic        feedback;
	logic [6:0]  len_cnt;
	logic        pulse;
	level_t      volume;

	volume_envelope u_env (
		.clk        (clk),
		.reset      (reset),
		.trigger    (trigger),
		.env_tick   (env_tick),
		.active     (ena),
		.vol_init   (vol_init),
		.vol_inc    (vol_inc),
		.vol_period (vol_period),
		.volume     (volume)
	);

	assign reload   = (18'h3ffff - {15'd0, div}) << shift;
	assign feedback = lfsr[1] ^ lfsr[0];

	always_comb begin
		lfsr_next = {feedback, lfsr[14:1]};
		if (width)
			lfsr_next[6] = feedback; // Short 7-bit sequence.
	end

	always_ff @(posedge clk) begin
		if (trigger) begin
			freq_cnt <= reload;
			lfsr     <= 15'h7fff;
			len_cnt  <= {1'b0, length};
			ena      <= 1'b1;
		end else begin
			if (freq_tick && ena) begin
				if (&freq_cnt) begin
					freq_cnt <= reload;
					lfsr     <= lfsr_next;
				end else begin
					freq_cnt <= freq_cnt + 18'd1;
				end
			end
			if (length_tick && ena && length_ena) begin
				if (len_cnt[6]) begin
					ena     <= 1'b0;
					len_cnt <= {1'b0, length};
				end else begin
					len_cnt <= len_cnt + 7'd1;
				end
			end
		end
		if (!master_ena)
			ena <= 1'b0;
		if (reset) begin
			ena     <= 1'b0;
			len_cnt <= '0;
		end
	end

	assign pulse = !lfsr[0];
	assign level = !ena  ? LEVEL_IDLE :
	               pulse ? LEVEL_IDLE + {1'b0, volume[3:1]} :
	               LEVEL_IDLE - ({1'b0, volume[3:1]} + {3'b000, volume[0]});

endmodule

// ==== rtl/square_voice.sv ====
`timescale 1ns/1ns

module square_voice import apu_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        master_ena,
	input  logic        trigger,
	input  logic        freq_tick,
	input  logic        length_tick,
	input  logic        env_tick,
	input  logic [1:0]  duty,
	input  logic [5:0]  length,
	input  logic        length_ena,
	input  logic [10:0] freq,
	input  logic [3:0]  vol_init,
	input  logic        vol_inc,
	input  logic [2:0]  vol_period,
	output level_t      level
);

	logic        ena;
	logic [10:0] freq_cnt;
	logic [2:0]  duty_step;
	logic [6:0]  len_cnt;
	logic        pulse;
	level_t      volume;
	level_t      half_down;
	level_t      half_up;

	volume_envelope u_env (
		.clk        (clk),
		.reset      (reset),
		.trigger    (trigger),
		.env_tick   (env_tick),
		.active     (ena),
		.vol_init   (vol_init),
		.vol_inc    (vol_inc),
		.vol_period (vol_period),
		.volume     (volume)
	);

	always_ff @(posedge clk) begin
		if (trigger) begin
			freq_cnt  <= freq;
			duty_step <= '0;
			len_cnt   <= {1'b0, length};
			ena       <= 1'b1;
		end else begin
			if (freq_tick && ena) begin
				if (&freq_cnt) begin
					freq_cnt  <= freq; // Period is 2048 minus freq ticks.
					duty_step <= duty_step + 3'd1;
				end else begin
					freq_cnt <= freq_cnt + 11'd1;
				end
			end
			if (length_tick && ena && length_ena) begin
				if (len_cnt[6]) begin
					ena     <= 1'b0; // Length expired.
					len_cnt <= {1'b0, length};
				end else begin
					len_cnt <= len_cnt + 7'd1;
				end
			end
		end
		if (!master_ena)
			ena <= 1'b0;
		if (reset) begin
			ena     <= 1'b0;
			len_cnt <= '0;
		end
	end

	assign pulse     = duty_step >= DUTY_THRESHOLD[duty];
	assign half_down = {1'b0, volume[3:1]};
	assign half_up   = {1'b0, volume[3:1]} + {3'b000, volume[0]};
	assign level     = !ena  ? LEVEL_IDLE :
	                   pulse ? LEVEL_IDLE + half_down : LEVEL_IDLE - half_up;

	// Power off reaches the level one edge after the register file drops master.
	idle_after_off: assert property (@(posedge clk) disable iff (reset)
		!master_ena |=> level == LEVEL_IDLE);

endmodule

// ==== rtl/stereo_mixer.sv ====
`timescale 1ns/1ns

module stereo_mixer import apu_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       master_ena,
	input  logic [2:0] route_left,
	input  logic [2:0] route_right,
	input  level_t     sq1_level,
	input  level_t     sq2_level,
	input  level_t     ns_level,
	output mix_t       left,
	output mix_t       right
);

	// Bit 0 is voice 1, bit 1 voice 2, bit 2 noise.
	function automatic mix_t side_sum(input logic [2:0] route, input level_t l1,
	                                  input level_t l2, input level_t l3);
		mix_t sum;
		sum = mix_t'(LEVEL_IDLE); // Absent wave slot.
		sum = sum + (route[0] ? l1 : LEVEL_IDLE);
		sum = sum + (route[1] ? l2 : LEVEL_IDLE);
		sum = sum + (route[2] ? l3 : LEVEL_IDLE);
		return sum;
	endfunction

	always_ff @(posedge clk) begin
		if (reset || !master_ena) begin
			left  <= MIX_IDLE;
			right <= MIX_IDLE;
		end else begin
			left  <= side_sum(route_left, sq1_level, sq2_level, ns_level);
			right <= side_sum(route_right, sq1_level, sq2_level, ns_level);
		end
	end

	// Voice levels top out at 15, so three voices and the idle wave slot stay in range.
	mix_in_range: assert property (@(posedge clk) disable iff (reset)
		left <= MIX_MAX && right <= MIX_MAX);

endmodule

// ==== rtl/volume_envelope.sv ====
`timescale 1ns/1ns

module volume_envelope import apu_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       trigger,
	input  logic       env_tick,
	input  logic       active,
	input  logic [3:0] vol_init,
	input  logic       vol_inc,
	input  logic [2:0] vol_period,
	output level_t     volume
);

	logic [2:0] count;
	logic [2:0] count_next;

	assign count_next = count + 3'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			count  <= '0;
			volume <= '0;
		end else if (trigger) begin
			count  <= '0;
			volume <= vol_init;
		end else if (env_tick && active && vol_period != 3'd0) begin
			// Period n steps once every n envelope ticks.
			if (count_next == vol_period) begin
				count <= '0;
				if (vol_inc) begin
					if (volume != 4'd15)
						volume <= volume + 4'd1; // Saturate at full.
				end else begin
					if (volume != 4'd0)
						volume <= volume - 4'd1;
				end
			end else begin
				count <= count_next;
			end
		end
	end

endmodule

// ==== verif/apu_tb.sv ====
`timescale 1ns/1ns

module apu_tb import apu_pkg::*; ();

	localparam int DIV_BITS     = 6;
	localparam int STEP_CYCLES  = 1 << DIV_BITS;     // One frame step.
	localparam int LEN_PLAY     = 3 * STEP_CYCLES;   // Two length ticks always pass first.
	localparam int LEN_WAIT     = 4 * 2 * STEP_CYCLES + 20;
	localparam int LEN_HOLD     = 2 * 2 * STEP_CYCLES;
	localparam int ENV_WAIT     = 17 * 8 * STEP_CYCLES;
	localparam int ENV_HOLD     = 200;
	localparam int SQ_WINDOW    = 5 * 32 * 19;       // Longest duty period is 32 * 19.
	localparam int NOISE_WINDOW = 600;
	localparam int OFF_HOLD     = 300;
	localparam int TIMEOUT_CYCLES = SQ_WINDOW + LEN_PLAY + LEN_WAIT + LEN_HOLD
	                              + ENV_WAIT + ENV_HOLD + NOISE_WINDOW + OFF_HOLD + 2000;

	localparam int MODE_OFF  = 0;
	localparam int MODE_IDLE = 1;
	localparam int MODE_PAIR = 2;
	localparam int MODE_ENV  = 3;

	logic        clk;
	logic        reset;
	logic [5:0]  addr;
	logic [7:0]  din;
	logic        write;
	mix_t        left;
	mix_t        right;

	string       test_name = "reset_idle";
	int          left_mode = MODE_OFF;
	int          right_mode = MODE_OFF;
	mix_t        left_hi, left_lo, right_hi, right_lo;
	bit          left_seen_hi, left_seen_lo, right_seen_hi, right_seen_lo;
	int          left_high_count, right_high_count;
	int          env_vol;
	int          error_count = 0;
	int          cycle_count = 0;
	int          sq_vol, sq_duty, sq_period, ns_vol, ns_div;
	logic [10:0] sq_freq;

	tb_clock u_clock (
		.clk   (clk),
		.reset (reset)
	);

	apu_top #(
		.DIV_BITS (DIV_BITS)
	) UUT (
		.clk   (clk),
		.reset (reset),
		.addr  (addr),
		.din   (din),
		.write (write),
		.left  (left),
		.right (right)
	);

	// Level of one voice by the rule: high adds half the volume, low subtracts it rounded up.
	function automatic level_t ref_level(input int vol, input bit high);
		if (high)
			return level_t'(LEVEL_IDLE + vol / 2);
		else
			return level_t'(LEVEL_IDLE - (vol + 1) / 2);
	endfunction

	// Bit 0 voice 1, bit 1 voice 2, bit 2 noise. Wave slot always idle.
	function automatic mix_t route_sum(input logic [2:0] route, input level_t sq1,
	                                   input level_t sq2, input level_t ns);
		int sum;
		sum = LEVEL_IDLE;
		sum += route[0] ? sq1 : LEVEL_IDLE;
		sum += route[1] ? sq2 : LEVEL_IDLE;
		sum += route[2] ? ns : LEVEL_IDLE;
		return mix_t'(sum);
	endfunction

	task automatic abort_run(input string reason);
		error_count++;
		$display("%s", reason);
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped after the first error.");
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
	                             input logic [31:0] actual);
		if (expected !== actual) begin
			error_count++;
			$display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
			$display("ERRORS FOUND");
			$fatal(1, "Simulation stopped after the first error.");
		end
	endtask

	task automatic match_pair(input string name, input mix_t actual, input mix_t hi,
	                          input mix_t lo, inout bit seen_hi, inout bit seen_lo,
	                          inout int high_count);
		if (actual === lo) begin
			seen_lo = 1'b1;
		end else begin
			compare_value(name, hi, actual);
			seen_hi = 1'b1;
			high_count++;
		end
	endtask

	task automatic host_write(input logic [5:0] a, input logic [7:0] d);
		@(negedge clk);
		addr  = a;
		din   = d;
		write = 1'b1;
		@(negedge clk);
		write = 1'b0; // Commits on the next rising edge.
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// Outputs are registered, so the rising edge sees the value of the past cycle.
	always @(posedge clk) begin : compare_outputs
		int  v;
		bit  found;
		found = 1'b0;
		if (left_mode == MODE_IDLE) begin
			compare_value({test_name, " left"}, MIX_IDLE, left);
		end else if (left_mode == MODE_PAIR) begin
			match_pair({test_name, " left"}, left, left_hi, left_lo,
			           left_seen_hi, left_seen_lo, left_high_count);
		end else if (left_mode == MODE_ENV) begin
			for (v = env_vol; v >= 0 && !found; v--) begin
				if (left === route_sum(3'b001, ref_level(v, 1'b1), LEVEL_IDLE, LEVEL_IDLE) ||
				    left === route_sum(3'b001, ref_level(v, 1'b0), LEVEL_IDLE, LEVEL_IDLE)) begin
					found   = 1'b1;
					env_vol = v; // Volume may only fall.
				end
			end
			if (!found)
				compare_value({test_name, " left"},
				              route_sum(3'b001, ref_level(env_vol, 1'b1), LEVEL_IDLE, LEVEL_IDLE),
				              left);
		end
		if (right_mode == MODE_IDLE)
			compare_value({test_name, " right"}, MIX_IDLE, right);
		else if (right_mode == MODE_PAIR)
			match_pair({test_name, " right"}, right, right_hi, right_lo,
			           right_seen_hi, right_seen_lo, right_high_count);
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
			abort_run($sformatf("Timeout: the run did not finish within %0d cycles.",
			                    TIMEOUT_CYCLES));
	end

	initial begin
		addr      = '0;
		din       = '0;
		write     = 1'b0;
		void'($urandom(16682));
		wait (!reset);
		wait_cycles(1);
		left_mode  = MODE_IDLE;
		right_mode = MODE_IDLE;
		wait_cycles(10);

		test_name = "master_off_writes"; // All ignored while powered down.
		host_write(NR51, 8'hff);
		host_write(NR12, 8'hf0);
		host_write(NR14, 8'h80);
		host_write(NR44, 8'h80);
		wait_cycles(20);

		test_name = "square_duty";
		host_write(NR52, 8'h80);
		host_write(NR51, 8'h10);
		left_mode = MODE_OFF;
		sq_vol    = 2 + $urandom % 14;
		sq_duty   = $urandom % 4;
		sq_period = 4 + $urandom % 16;
		sq_freq   = 11'(2048 - sq_period);
		host_write(NR11, {sq_duty[1:0], 6'd0});
		host_write(NR12, {sq_vol[3:0], 4'h0});
		host_write(NR13, sq_freq[7:0]);
		host_write(NR14, {5'b10000, sq_freq[10:8]});
		wait_cycles(4);
		left_hi   = route_sum(3'b001, ref_level(sq_vol, 1'b1), LEVEL_IDLE, LEVEL_IDLE);
		left_lo   = route_sum(3'b001, ref_level(sq_vol, 1'b0), LEVEL_IDLE, LEVEL_IDLE);
		left_mode = MODE_PAIR;
		wait_cycles(32 * sq_period); // First step after trigger may be short.
		left_seen_hi    = 1'b0;
		left_seen_lo    = 1'b0;
		left_high_count = 0;
		wait_cycles(4 * 32 * sq_period);
		left_mode = MODE_OFF;
		if (!left_seen_hi || !left_seen_lo)
			abort_run("Voice 1 did not show both its high and its low level on the left side.");
		compare_value("square_duty high samples",
		              4 * (8 - DUTY_THRESHOLD[sq_duty]) * 4 * sq_period, left_high_count);

		test_name  = "length_expire";
		right_mode = MODE_OFF;
		host_write(NR51, 8'h22);
		host_write(NR21, {2'b10, 6'd62}); // Three length ticks to expire.
		host_write(NR22, 8'hc0);
		host_write(NR23, sq_freq[7:0]);
		host_write(NR24, {5'b11000, sq_freq[10:8]});
		wait_cycles(4);
		left_hi    = route_sum(3'b010, LEVEL_IDLE, ref_level(12, 1'b1), LEVEL_IDLE);
		left_lo    = route_sum(3'b010, LEVEL_IDLE, ref_level(12, 1'b0), LEVEL_IDLE);
		right_hi   = left_hi;
		right_lo   = left_lo;
		left_mode  = MODE_PAIR;
		right_mode = MODE_PAIR;
		wait_cycles(LEN_PLAY); // Voice 2 still sounds on both sides.
		left_mode  = MODE_OFF;
		right_mode = MODE_OFF;
		wait_cycles(LEN_WAIT);
		left_mode  = MODE_IDLE;
		right_mode = MODE_IDLE;
		wait_cycles(LEN_HOLD);

		test_name = "envelope_decay";
		left_mode = MODE_OFF;
		host_write(NR12, 8'hf1);
		host_write(NR51, 8'h10);
		host_write(NR14, {5'b10000, sq_freq[10:8]});
		wait_cycles(4);
		env_vol   = 15;
		left_mode = MODE_ENV;
		wait_cycles(ENV_WAIT);
		left_mode = MODE_IDLE;
		wait_cycles(ENV_HOLD);

		test_name = "noise_7bit";
		ns_vol    = 2 + $urandom % 14;
		ns_div    = $urandom % 8;
		host_write(NR42, {ns_vol[3:0], 4'h0});
		host_write(NR43, {4'd0, 1'b1, ns_div[2:0]});
		host_write(NR51, 8'h08);
		right_mode = MODE_OFF;
		host_write(NR44, 8'h80);
		wait_cycles(4);
		right_hi      = route_sum(3'b100, LEVEL_IDLE, LEVEL_IDLE, ref_level(ns_vol, 1'b1));
		right_lo      = route_sum(3'b100, LEVEL_IDLE, LEVEL_IDLE, ref_level(ns_vol, 1'b0));
		right_seen_hi = 1'b0;
		right_seen_lo = 1'b0;
		right_mode    = MODE_PAIR;
		wait_cycles(NOISE_WINDOW);
		if (!right_seen_hi || !right_seen_lo)
			abort_run("The noise voice did not show both its levels on the right side.");

		test_name  = "master_off";
		left_mode  = MODE_OFF;
		right_mode = MODE_OFF;
		host_write(NR12, 8'ha0);
		host_write(NR51, 8'h18);
		host_write(NR14, {5'b10000, sq_freq[10:8]});
		wait_cycles(4);
		host_write(NR52, 8'h00);
		wait_cycles(2); // Two edges to go silent.
		left_mode  = MODE_IDLE;
		right_mode = MODE_IDLE;
		wait_cycles(20);
		host_write(NR44, 8'h80);
		host_write(NR52, 8'h80);
		host_write(NR51, 8'hff); // Voices stay silent until triggered.
		wait_cycles(OFF_HOLD);

		left_mode  = MODE_OFF;
		right_mode = MODE_OFF;
		wait_cycles(2);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk); // Release away from the rising edge.
		reset = 1'b0;
	end

endmodule
